// ==== src/rv_cfg.svh ====
// RV32I constants; reset address is a build-time value and ALU codes mirror funct3 where they can
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// ==========================================================================
// Reset and opcodes
// ==========================================================================
`define RV_RESET_ADDR 32'h0000_0000
`define RV_OP_OP      7'b0110011  // Register-register ALU
`define RV_OP_OP_IMM  7'b0010011  // Register-immediate ALU
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_JAL     7'b1101111
`define RV_OP_JALR    7'b1100111
`define RV_OP_LUI     7'b0110111
`define RV_OP_AUIPC   7'b0010111
`define RV_OP_SYSTEM  7'b1110011  // Only EBREAK is acted on

// ==========================================================================
// ALU select, SLTU is SLT plus unsigned flag
// ==========================================================================
`define RV_ALU_ADD 3'd0
`define RV_ALU_SLL 3'd1
`define RV_ALU_SLT 3'd2
`define RV_ALU_XOR 3'd4
`define RV_ALU_SRL 3'd5  // SRA with arith flag
`define RV_ALU_OR  3'd6
`define RV_ALU_AND 3'd7

// Access sizes, bit 2 marks zero extension on loads
`define RV_F3_B  3'b000
`define RV_F3_H  3'b001
`define RV_F3_W  3'b010
`define RV_F3_BU 3'b100
`define RV_F3_HU 3'b101

// Branch kinds
`define RV_F3_BEQ  3'b000
`define RV_F3_BNE  3'b001
`define RV_F3_BLT  3'b100
`define RV_F3_BGE  3'b101
`define RV_F3_BLTU 3'b110
`define RV_F3_BGEU 3'b111

`endif

// ==== src/rv_pkg.sv ====
// Shared RV32I datapath types; widths are fixed to the 32-bit base ISA
package rv_pkg;

    typedef logic [31:0] word_t;     // Data, address or instruction
    typedef logic [4:0]  reg_idx_t;  // Register index
    typedef logic [2:0]  alu_sel_t;  // ALU operation select
    typedef logic [2:0]  funct3_t;   // Access size or branch kind

    // Decoded control for one instruction
    typedef struct packed {
        alu_sel_t alu_sel;
        logic     sub;          // ADD becomes SUB
        logic     is_unsigned;  // SLTU and unsigned branches
        logic     arith;        // SRA instead of SRL
        logic     use_imm;      // Operand 2 from immediate
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     is_branch;
        logic     is_jal;
        logic     is_jalr;
        logic     is_lui;
        logic     is_auipc;
        logic     illegal;      // Unknown opcode
        logic     ebreak;
        funct3_t  funct3;
    } ctrl_t;

    // Data-memory request, addr is word aligned
    typedef struct packed {
        word_t       addr;
        logic        ren;
        logic        wen;
        word_t       wdata;
        logic [3:0]  mask;  // One bit per byte lane
    } dmem_req_t;

    // Per-cycle retire record
    typedef struct packed {
        word_t    inst;
        word_t    pc;
        word_t    next_pc;
        word_t    rd_wdata;
        reg_idx_t rd_waddr;  // Zero for branches and stores
        logic     trap;
        logic     halt;
    } retire_t;

endpackage

// ==== src/rv_decode.sv ====
// Combinational RV32I decoder; funct7 is checked only at bit 5, so other funct7 values alias
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_decode import rv_pkg::*; (
    input  word_t i_inst,
    output ctrl_t o_ctrl,
    output word_t o_imm
);

    logic [6:0] opcode;
    funct3_t    f3;
    logic       f7_b5;      // funct7 bit 5, SUB and SRA
    alu_sel_t   f3_sel;     // ALU op implied by funct3

    assign opcode = i_inst[6:0];
    assign f3     = i_inst[14:12];
    assign f7_b5  = i_inst[30];

    // funct3 to ALU select for OP and OP_IMM
    always_comb begin
        case (f3)
            3'b000:         f3_sel = `RV_ALU_ADD;
            3'b001:         f3_sel = `RV_ALU_SLL;
            3'b010, 3'b011: f3_sel = `RV_ALU_SLT;  // SLTU via unsigned flag
            3'b100:         f3_sel = `RV_ALU_XOR;
            3'b101:         f3_sel = `RV_ALU_SRL;
            3'b110:         f3_sel = `RV_ALU_OR;
            default:        f3_sel = `RV_ALU_AND;
        endcase
    end

    // ======================================================================
    // Control by opcode class
    // ======================================================================
    always_comb begin
        o_ctrl         = '0;
        o_ctrl.funct3  = f3;
        o_ctrl.alu_sel = `RV_ALU_ADD;  // Address and default add
        o_imm          = {{20{i_inst[31]}}, i_inst[31:20]};  // I-type
        case (opcode)
            `RV_OP_OP: begin
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.alu_sel     = f3_sel;
                o_ctrl.sub         = f7_b5 & (f3 == 3'b000);
                o_ctrl.arith       = f7_b5 & (f3 == 3'b101);
                o_ctrl.is_unsigned = (f3 == 3'b011);
            end
            `RV_OP_OP_IMM: begin
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.use_imm     = 1'b1;
                o_ctrl.alu_sel     = f3_sel;
                o_ctrl.arith       = f7_b5 & (f3 == 3'b101);  // SRAI
                o_ctrl.is_unsigned = (f3 == 3'b011);
            end
            `RV_OP_LOAD: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.use_imm   = 1'b1;
                o_ctrl.mem_read  = 1'b1;
            end
            `RV_OP_STORE: begin
                o_ctrl.use_imm   = 1'b1;
                o_ctrl.mem_write = 1'b1;
                o_imm = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
            end
            `RV_OP_BRANCH: begin
                o_ctrl.is_branch   = 1'b1;
                o_ctrl.is_unsigned = f3[1];  // BLTU, BGEU
                o_imm = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                         i_inst[11:8], 1'b0};
            end
            `RV_OP_JAL: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.is_jal    = 1'b1;
                o_imm = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                         i_inst[30:21], 1'b0};
            end
            `RV_OP_JALR: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.is_jalr   = 1'b1;
            end
            `RV_OP_LUI: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.is_lui    = 1'b1;
                o_imm = {i_inst[31:12], 12'b0};
            end
            `RV_OP_AUIPC: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.is_auipc  = 1'b1;
                o_imm = {i_inst[31:12], 12'b0};
            end
            `RV_OP_SYSTEM: o_ctrl.ebreak = (i_inst == 32'h0010_0073);  // ECALL etc. are no-ops
            default:       o_ctrl.illegal = 1'b1;
        endcase
    end

endmodule

// ==== src/rv_regfile.sv ====
// Integer register file; x0 is not stored, reads are combinational and writes land at the edge
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst,
    input  reg_idx_t i_rs1_addr,
    input  reg_idx_t i_rs2_addr,
    input  reg_idx_t i_rd_addr,
    input  word_t    i_rd_data,
    input  logic     i_rd_wen,
    output word_t    o_rs1_data,
    output word_t    o_rs2_data
);

    word_t regs [1:31];  // x1..x31

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_wen && (i_rd_addr != '0)) begin  // x0 writes dropped
            regs[i_rd_addr] <= i_rd_data;
        end
    end

    // x0 reads as zero
    assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

// ==== src/rv_alu.sv ====
// 32-bit RV32I ALU; shift amount is the low five bits of operand 2, flags compare raw operands
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_alu import rv_pkg::*; (
    input  alu_sel_t i_sel,
    input  logic     i_sub,
    input  logic     i_unsigned,
    input  logic     i_arith,
    input  word_t    i_op1,
    input  word_t    i_op2,
    output word_t    o_result,
    output logic     o_eq,
    output logic     o_lt
);

    word_t      op2_x;  // Inverted for subtract
    word_t      sum;
    logic [4:0] shamt;

    assign op2_x = i_sub ? ~i_op2 : i_op2;
    assign sum   = i_op1 + op2_x + {31'b0, i_sub};  // Two's complement carry-in
    assign shamt = i_op2[4:0];

    // Flags also drive branch decisions
    assign o_eq = (i_op1 == i_op2);
    assign o_lt = i_unsigned ? (i_op1 < i_op2) : ($signed(i_op1) < $signed(i_op2));

    always_comb begin
        case (i_sel)
            `RV_ALU_ADD: o_result = sum;
            `RV_ALU_SLL: o_result = i_op1 << shamt;
            `RV_ALU_SLT: o_result = {31'b0, o_lt};
            `RV_ALU_XOR: o_result = i_op1 ^ i_op2;
            `RV_ALU_SRL: o_result = i_arith ? word_t'($signed(i_op1) >>> shamt)
                                            : i_op1 >> shamt;
            `RV_ALU_OR:  o_result = i_op1 | i_op2;
            `RV_ALU_AND: o_result = i_op1 & i_op2;
            default:     o_result = sum;  // Code 3 unused
        endcase
    end

endmodule

// ==== src/rv_branch.sv ====
// Next-PC logic; a misaligned taken target is flagged but still taken, nothing redirects it
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_branch import rv_pkg::*; (
    input  ctrl_t i_ctrl,
    input  word_t i_pc,
    input  word_t i_imm,
    input  word_t i_rs1,
    input  logic  i_eq,
    input  logic  i_lt,  // Signedness already chosen by decode
    output word_t o_next_pc,
    output logic  o_bad_target
);

    logic  cond;
    logic  taken;      // Branch or jump redirects
    word_t pc_rel;     // Branch and JAL target
    word_t jalr_tgt;

    always_comb begin
        case (i_ctrl.funct3)
            `RV_F3_BEQ:  cond = i_eq;
            `RV_F3_BNE:  cond = ~i_eq;
            `RV_F3_BLT:  cond = i_lt;
            `RV_F3_BGE:  cond = ~i_lt;
            `RV_F3_BLTU: cond = i_lt;
            `RV_F3_BGEU: cond = ~i_lt;
            default:     cond = 1'b0;  // Reserved kinds never branch
        endcase
    end

    assign pc_rel   = i_pc + i_imm;
    assign jalr_tgt = (i_rs1 + i_imm) & ~32'd1;  // Bit 0 cleared
    assign taken    = i_ctrl.is_jal | i_ctrl.is_jalr | (i_ctrl.is_branch & cond);

    assign o_next_pc    = i_ctrl.is_jalr ? jalr_tgt :
                          taken          ? pc_rel   :
                                           i_pc + 32'd4;
    assign o_bad_target = taken & (o_next_pc[1:0] != 2'b00);

endmodule

// ==== src/rv_lsu.sv ====
// Load/store lane logic for a 32-bit word memory; misaligned accesses are flagged, not split
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_lsu import rv_pkg::*; (
    input  ctrl_t      i_ctrl,
    input  word_t      i_addr,        // rs1 + imm from the ALU
    input  word_t      i_store_data,
    input  word_t      i_rdata,
    output word_t      o_addr,
    output word_t      o_wdata,
    output logic [3:0] o_mask,
    output word_t      o_load_data,
    output logic       o_misaligned
);

    logic [1:0] off;      // Byte offset in word
    funct3_t    size;     // Size only, sign bit dropped
    word_t      lane;     // Read data moved down to bit 0

    assign off    = i_addr[1:0];
    assign size   = {1'b0, i_ctrl.funct3[1:0]};
    assign o_addr = {i_addr[31:2], 2'b00};

    // ======================================================================
    // Store side
    // ======================================================================
    assign o_wdata = i_store_data << {off, 3'b000};

    always_comb begin
        case (size)
            `RV_F3_B: o_mask = 4'b0001 << off;
            `RV_F3_H: o_mask = 4'b0011 << off;
            default:  o_mask = 4'b1111;
        endcase
    end

    // ======================================================================
    // Load side
    // ======================================================================
    assign lane = i_rdata >> {off, 3'b000};

    always_comb begin
        case (i_ctrl.funct3)
            `RV_F3_B:  o_load_data = {{24{lane[7]}}, lane[7:0]};
            `RV_F3_H:  o_load_data = {{16{lane[15]}}, lane[15:0]};
            `RV_F3_BU: o_load_data = {24'b0, lane[7:0]};
            `RV_F3_HU: o_load_data = {16'b0, lane[15:0]};
            default:   o_load_data = i_rdata;  // LW and reserved
        endcase
    end

    // Word needs offset 0, half needs even offset
    assign o_misaligned = (i_ctrl.mem_read | i_ctrl.mem_write) &
                          (((size == `RV_F3_W) & (off != 2'b00)) |
                           ((size == `RV_F3_H) & off[0]));

endmodule

// ==== src/rv_hart.sv ====
// RV32I single-cycle hart; imem and dmem reads must be combinational, halt does not stop fetch
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_hart import rv_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    output word_t     o_imem_raddr,
    input  word_t     i_imem_rdata,
    output dmem_req_t o_dmem,
    input  word_t     i_dmem_rdata,
    output retire_t   o_retire
);

    word_t      pc, pc_plus4, next_pc;
    word_t      imm, rs1_data, rs2_data, op2, alu_res, rd_wdata;
    word_t      mem_addr, mem_wdata, load_data;
    ctrl_t      ctrl;
    logic [3:0] mem_mask;
    logic       eq, lt, bad_target, misaligned, trap;
    reg_idx_t   rs1, rs2, rd;

    assign rs1 = i_imem_rdata[19:15];
    assign rs2 = i_imem_rdata[24:20];
    assign rd  = i_imem_rdata[11:7];

    // ======================================================================
    // PC
    // ======================================================================
    always_ff @(posedge i_clk) begin
        if (i_rst) pc <= `RV_RESET_ADDR;
        else       pc <= next_pc;  // One instruction per cycle
    end
    assign pc_plus4     = pc + 32'd4;
    assign o_imem_raddr = pc;

    rv_decode u_rv_decode (.i_inst(i_imem_rdata), .o_ctrl(ctrl), .o_imm(imm));

    rv_regfile u_rv_regfile (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_rs1_addr(rs1), .i_rs2_addr(rs2),
        .i_rd_addr(rd), .i_rd_data(rd_wdata),
        .i_rd_wen(ctrl.reg_write & ~i_rst),  // No writes during reset
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
    );

    assign op2 = ctrl.use_imm ? imm : rs2_data;

    rv_alu u_rv_alu (
        .i_sel(ctrl.alu_sel), .i_sub(ctrl.sub),
        .i_unsigned(ctrl.is_unsigned), .i_arith(ctrl.arith),
        .i_op1(rs1_data), .i_op2(op2),
        .o_result(alu_res), .o_eq(eq), .o_lt(lt)
    );

    rv_branch u_rv_branch (
        .i_ctrl(ctrl), .i_pc(pc), .i_imm(imm), .i_rs1(rs1_data),
        .i_eq(eq), .i_lt(lt),
        .o_next_pc(next_pc), .o_bad_target(bad_target)
    );

    rv_lsu u_rv_lsu (
        .i_ctrl(ctrl), .i_addr(alu_res), .i_store_data(rs2_data), .i_rdata(i_dmem_rdata),
        .o_addr(mem_addr), .o_wdata(mem_wdata), .o_mask(mem_mask),
        .o_load_data(load_data), .o_misaligned(misaligned)
    );

    // Write-back priority: load, link, LUI, AUIPC, ALU
    assign rd_wdata = ctrl.mem_read                 ? load_data :
                      (ctrl.is_jal | ctrl.is_jalr)  ? pc_plus4  :
                      ctrl.is_lui                   ? imm       :
                      ctrl.is_auipc                 ? pc + imm  :
                                                      alu_res;

    assign trap = ctrl.illegal | bad_target | misaligned;

    assign o_dmem = '{addr: mem_addr, ren: ctrl.mem_read & ~i_rst,
                      wen: ctrl.mem_write & ~i_rst, wdata: mem_wdata, mask: mem_mask};

    // Branches and stores report no destination
    assign o_retire = '{inst: i_imem_rdata, pc: pc, next_pc: next_pc, rd_wdata: rd_wdata,
                        rd_waddr: (ctrl.is_branch | ctrl.mem_write) ? reg_idx_t'(0) : rd,
                        trap: trap, halt: trap | ctrl.ebreak};

endmodule

// ==== tests/rv_hart_checker.sv ====
// Hart port assertions for bind; assumes reset spans at least one rising edge before use
`timescale 1ns/1ps

module rv_hart_checker import rv_pkg::*; (
    input logic      i_clk,
    input logic      i_rst,
    input word_t     i_imem_raddr,
    input dmem_req_t i_dmem,
    input retire_t   i_retire
);

    int n_errors = 0;  // Failed assertions so far

    // ======================================================================
    // Data-memory port
    // ======================================================================
    a_one_enable: assert property (@(posedge i_clk) !(i_dmem.ren && i_dmem.wen))
        else begin
            $error("Data memory read and write enables high in the same cycle");
            n_errors++;
        end

    a_reset_quiet: assert property (@(posedge i_clk) i_rst |-> (!i_dmem.ren && !i_dmem.wen))
        else begin
            $error("Data memory enable high during reset");
            n_errors++;
        end

    a_write_mask: assert property (@(posedge i_clk) disable iff (i_rst)
                                   i_dmem.wen |-> (i_dmem.mask != 4'b0000))
        else begin
            $error("Store issued with an empty byte mask");
            n_errors++;
        end

    // Fetch stays word aligned unless a trap let a bad target through
    a_fetch_align: assert property (@(posedge i_clk) disable iff (i_rst)
                                    !$past(i_retire.trap) |-> (i_imem_raddr[1:0] == 2'b00))
        else begin
            $error("Fetch address misaligned after a cycle without trap");
            n_errors++;
        end

endmodule

// ==== tests/rv_hart_tb.sv ====
// Hart testbench; the program is a fixed execution trace and memories return per-row table values
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_hart_tb import rv_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int NMAX       = 40;   // Table capacity

    logic      i_clk;
    logic      i_rst;
    word_t     o_imem_raddr;
    word_t     i_imem_rdata;
    dmem_req_t o_dmem;
    word_t     i_dmem_rdata;
    retire_t   o_retire;

    // Stimulus and expected-value table, one row per cycle
    word_t      t_inst  [NMAX];
    word_t      t_rdata [NMAX];  // Data memory read value
    reg_idx_t   t_waddr [NMAX];
    word_t      t_wdata [NMAX];  // Checked only when t_waddr is nonzero
    word_t      t_npc   [NMAX];
    logic       t_ren   [NMAX];
    logic       t_wen   [NMAX];
    word_t      t_maddr [NMAX];  // Word-aligned data address
    logic [3:0] t_mask  [NMAX];
    word_t      t_mwdata[NMAX];
    logic       t_trap  [NMAX];
    logic       t_halt  [NMAX];
    string      t_name  [NMAX];
    int         nrows = 0;
    logic       table_ready = 1'b0;

    word_t  xr [32];  // Architectural register model
    word_t  pc_m;     // Model PC of the row being built
    integer seed;

    rv_hart u_rv_hart (
        .i_clk(i_clk), .i_rst(i_rst),
        .o_imem_raddr(o_imem_raddr), .i_imem_rdata(i_imem_rdata),
        .o_dmem(o_dmem), .i_dmem_rdata(i_dmem_rdata),
        .o_retire(o_retire)
    );

    bind rv_hart rv_hart_checker u_rv_hart_checker (
        .i_clk(i_clk), .i_rst(i_rst), .i_imem_raddr(o_imem_raddr),
        .i_dmem(o_dmem), .i_retire(o_retire)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // ======================================================================
    // Failure reporting and compare tasks
    // ======================================================================
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %s: expected x%0d, actual x%0d", name, exp, act));
        end
    endtask

    task automatic check_mask(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // ======================================================================
    // Instruction encoders, straight from the RV32I formats
    // ======================================================================
    function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input funct3_t f3, input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, `RV_OP_OP};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input funct3_t f3, input reg_idx_t rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input funct3_t f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input funct3_t f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    function automatic word_t enc_u(input logic [19:0] imm, input reg_idx_t rd,
                                    input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic word_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // ======================================================================
    // Row builders, each one advances the model PC
    // ======================================================================
    task automatic push(input string name, input word_t inst, input word_t rdata,
                        input reg_idx_t waddr, input word_t wdata, input word_t npc,
                        input logic ren, input logic wen, input word_t maddr,
                        input logic [3:0] mask, input word_t mwdata,
                        input logic trap, input logic halt);
        t_name[nrows]   = name;
        t_inst[nrows]   = inst;
        t_rdata[nrows]  = rdata;
        t_waddr[nrows]  = waddr;
        t_wdata[nrows]  = wdata;
        t_npc[nrows]    = npc;
        t_ren[nrows]    = ren;
        t_wen[nrows]    = wen;
        t_maddr[nrows]  = maddr;
        t_mask[nrows]   = mask;
        t_mwdata[nrows] = mwdata;
        t_trap[nrows]   = trap;
        t_halt[nrows]   = halt;
        nrows++;
        pc_m = npc;
    endtask

    task automatic alu_row(input string name, input word_t inst, input word_t res);
        reg_idx_t rd;
        rd = inst[11:7];
        push(name, inst, '0, rd, res, pc_m + 32'd4, 1'b0, 1'b0, '0, 4'b0, '0, 1'b0, 1'b0);
        if (rd != 0) xr[rd] = res;  // x0 stays zero
    endtask

    task automatic br_row(input string name, input word_t inst, input logic taken,
                          input word_t off);
        push(name, inst, '0, '0, '0, taken ? pc_m + off : pc_m + 32'd4,
             1'b0, 1'b0, '0, 4'b0, '0, 1'b0, 1'b0);
    endtask

    task automatic jmp_row(input string name, input word_t inst, input word_t target);
        reg_idx_t rd;
        word_t    link;
        rd   = inst[11:7];
        link = pc_m + 32'd4;
        push(name, inst, '0, rd, link, target, 1'b0, 1'b0, '0, 4'b0, '0, 1'b0, 1'b0);
        if (rd != 0) xr[rd] = link;
    endtask

    task automatic st_row(input string name, input word_t inst, input word_t maddr,
                          input logic [3:0] mask, input word_t mwdata);
        push(name, inst, '0, '0, '0, pc_m + 32'd4, 1'b0, 1'b1, maddr, mask, mwdata,
             1'b0, 1'b0);
    endtask

    task automatic ld_row(input string name, input word_t inst, input word_t maddr,
                          input word_t rdata, input word_t exp, input logic trap);
        reg_idx_t rd;
        rd = inst[11:7];
        push(name, inst, rdata, rd, exp, pc_m + 32'd4, 1'b1, 1'b0, maddr, 4'b0, '0,
             trap, trap);
        if (rd != 0) xr[rd] = exp;
    endtask

    // ======================================================================
    // Program, a straight execution trace from the reset address
    // ======================================================================
    task automatic build_program();
        word_t rnd;
        foreach (xr[k]) xr[k] = '0;
        pc_m = `RV_RESET_ADDR;
        rnd  = $random(seed);
        alu_row("lui_rand", enc_u(rnd[19:0], 1, `RV_OP_LUI), {rnd[19:0], 12'h000});
        rnd  = $random(seed);
        alu_row("addi_rand", enc_i(rnd[11:0], 1, 3'b000, 1, `RV_OP_OP_IMM),
                xr[1] + sext12(rnd[11:0]));
        alu_row("addi_neg", enc_i(12'hF9C, 0, 3'b000, 2, `RV_OP_OP_IMM), 32'hFFFF_FF9C);
        alu_row("add", enc_r(7'h00, 2, 1, 3'b000, 3), xr[1] + xr[2]);
        alu_row("sub", enc_r(7'h20, 2, 1, 3'b000, 4), xr[1] - xr[2]);
        alu_row("slt_neg", enc_r(7'h00, 0, 2, 3'b010, 5), 32'd1);   // -100 < 0 signed
        alu_row("sltu_neg", enc_r(7'h00, 0, 2, 3'b011, 6), 32'd0);  // Huge unsigned
        alu_row("addi_four", enc_i(12'd4, 0, 3'b000, 7, `RV_OP_OP_IMM), 32'd4);
        alu_row("sra", enc_r(7'h20, 7, 2, 3'b101, 8), 32'hFFFF_FFF9);  // -100 >>> 4
        alu_row("srl", enc_r(7'h00, 7, 2, 3'b101, 9), 32'h0FFF_FFF9);
        alu_row("auipc", enc_u(20'h12345, 10, `RV_OP_AUIPC), pc_m + 32'h1234_5000);
        alu_row("addi_x0", enc_i(12'd5, 1, 3'b000, 0, `RV_OP_OP_IMM), xr[1] + 32'd5);
        alu_row("x0_reads_zero", enc_r(7'h00, 1, 0, 3'b000, 11), xr[0] + xr[1]);

        // Branch offsets in bytes
        br_row("beq_taken", enc_b(13'd8, 1, 1, `RV_F3_BEQ), xr[1] == xr[1], 32'd8);
        br_row("beq_not_taken", enc_b(13'd8, 2, 0, `RV_F3_BEQ), xr[0] == xr[2], 32'd8);
        br_row("bltu_taken", enc_b(13'd16, 2, 0, `RV_F3_BLTU), xr[0] < xr[2], 32'd16);
        br_row("bltu_not_taken", enc_b(13'd16, 0, 2, `RV_F3_BLTU), xr[2] < xr[0], 32'd16);
        jmp_row("jal", enc_j(21'd24, 12), pc_m + 32'd24);
        jmp_row("jalr_bit0", enc_i(12'h101, 7, 3'b000, 13, `RV_OP_JALR),
                (xr[7] + 32'h101) & ~32'h1);

        // Loads and stores off a base of 0x100
        alu_row("addi_base", enc_i(12'h100, 0, 3'b000, 15, `RV_OP_OP_IMM), 32'h100);
        st_row("sb_off3", enc_s(12'd3, 2, 15, `RV_F3_B), 32'h100, 4'b1000, xr[2] << 24);
        st_row("sh_off2", enc_s(12'd2, 2, 15, `RV_F3_H), 32'h100, 4'b1100, xr[2] << 16);
        st_row("sw_off0", enc_s(12'd0, 1, 15, `RV_F3_W), 32'h100, 4'b1111, xr[1]);
        ld_row("lb_sign", enc_i(12'd1, 15, `RV_F3_B, 16, `RV_OP_LOAD), 32'h100,
               32'h0000_8000, 32'hFFFF_FF80, 1'b0);
        ld_row("lbu_zero", enc_i(12'd1, 15, `RV_F3_BU, 17, `RV_OP_LOAD), 32'h100,
               32'h0000_8000, 32'h0000_0080, 1'b0);
        ld_row("lh_upper", enc_i(12'd2, 15, `RV_F3_H, 18, `RV_OP_LOAD), 32'h100,
               32'h8765_1234, 32'hFFFF_8765, 1'b0);
        ld_row("lw_misaligned", enc_i(12'd1, 15, `RV_F3_W, 19, `RV_OP_LOAD), 32'h100,
               32'hDEAD_BEEF, 32'hDEAD_BEEF, 1'b1);  // Trap still writes the word

        // Opcode zero is unknown, rd field zero
        push("illegal", 32'h0000_0000, '0, '0, '0, pc_m + 32'd4, 1'b0, 1'b0, '0, 4'b0, '0,
             1'b1, 1'b1);
        push("ebreak", 32'h0010_0073, '0, '0, '0, pc_m + 32'd4, 1'b0, 1'b0, '0, 4'b0, '0,
             1'b0, 1'b1);
    endtask

    // ======================================================================
    // Watchdog
    // ======================================================================
    initial begin
        wait (table_ready);
        #((16 + nrows + 10) * CLK_PERIOD);
        abort_run($sformatf("Timeout, run did not finish within %0d cycles", 16 + nrows + 10));
    end

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        word_t exp_addr;
        i_clk        = 1'b0;
        i_rst        = 1'b1;
        i_dmem_rdata = '0;
        i_imem_rdata = enc_s(12'd0, 0, 0, `RV_F3_W);  // A store, must stay gated
        seed         = 98702;
        build_program();
        table_ready  = 1'b1;

        for (int r = 0; r < 16; r++) begin
            @(posedge i_clk);
            #1;
            check_flag("reset ren", 1'b0, o_dmem.ren);
            check_flag("reset wen", 1'b0, o_dmem.wen);
            // Load and store take turns, both must stay gated
            i_imem_rdata = (r % 2 == 0) ? enc_i(12'd0, 0, `RV_F3_W, 1, `RV_OP_LOAD)
                                        : enc_s(12'd0, 0, 0, `RV_F3_W);
        end
        i_rst    = 1'b0;
        exp_addr = `RV_RESET_ADDR;

        for (int i = 0; i < nrows; i++) begin
            i_imem_rdata = t_inst[i];
            i_dmem_rdata = t_rdata[i];
            @(negedge i_clk);  // Mid-cycle, combinational outputs settled
            check_word({t_name[i], " imem_raddr"}, exp_addr, o_imem_raddr);
            check_word({t_name[i], " pc"}, exp_addr, o_retire.pc);
            check_word({t_name[i], " inst"}, t_inst[i], o_retire.inst);
            check_idx({t_name[i], " rd_waddr"}, t_waddr[i], o_retire.rd_waddr);
            if (t_waddr[i] != 0) begin
                check_word({t_name[i], " rd_wdata"}, t_wdata[i], o_retire.rd_wdata);
            end
            check_word({t_name[i], " next_pc"}, t_npc[i], o_retire.next_pc);
            check_flag({t_name[i], " ren"}, t_ren[i], o_dmem.ren);
            check_flag({t_name[i], " wen"}, t_wen[i], o_dmem.wen);
            if (t_ren[i] || t_wen[i]) begin
                check_word({t_name[i], " maddr"}, t_maddr[i], o_dmem.addr);
            end
            if (t_wen[i]) begin
                check_mask({t_name[i], " mask"}, t_mask[i], o_dmem.mask);
                check_word({t_name[i], " wdata"}, t_mwdata[i], o_dmem.wdata);
            end
            check_flag({t_name[i], " trap"}, t_trap[i], o_retire.trap);
            check_flag({t_name[i], " halt"}, t_halt[i], o_retire.halt);
            exp_addr = t_npc[i];
            @(posedge i_clk);
            #1;
        end

        if (u_rv_hart.u_rv_hart_checker.n_errors == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            abort_run($sformatf("%0d assertion failures in the bound checker",
                                u_rv_hart.u_rv_hart_checker.n_errors));
        end
    end

endmodule

// ==== all.f ====
+incdir+src
src/rv_pkg.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_branch.sv
src/rv_lsu.sv
src/rv_hart.sv
tests/rv_hart_checker.sv
tests/rv_hart_tb.sv

// ==== Bender.yml ====
package:
  name: rv_hart

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/rv_pkg.sv
      - src/rv_decode.sv
      - src/rv_regfile.sv
      - src/rv_alu.sv
      - src/rv_branch.sv
      - src/rv_lsu.sv
      - src/rv_hart.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/rv_hart_checker.sv
      - tests/rv_hart_tb.sv
